// File: seven_segment_peripheral.f
hw/seg_bus_pkg.sv
hw/seg_display_pkg.sv
hw/bus_register.sv
hw/bus_slave_port.sv
hw/display_scanner.sv
hw/seven_segment_peripheral.sv
verification/clock_gen.sv
verification/seven_segment_tb.sv

// File: verification/seven_segment_tb.sv
// testbench for the seven-segment peripheral: bus transfers, shadow model and assertions
`timescale 1ns/1ps

module seven_segment_tb;
    import seg_bus_pkg::*;
    import seg_display_pkg::*;

    localparam int          clk_period  = 8;
    localparam logic [15:0] base_addr   = 16'hFF10;
    localparam int          refresh_div = 4;
    localparam int          wait_limit  = 64;

    // cycles each test may take
    localparam int reset_budget    = 140;
    localparam int readback_budget = 150;
    localparam int window_budget   = 150;
    localparam int stall_budget    = 150;
    localparam int scan_budget     = 1000;
    localparam int dark_budget     = 150;
    localparam int total_budget    = reset_budget + readback_budget + window_budget
                                   + stall_budget + scan_budget + dark_budget;

    // lit segments a..g per hex value, a in the top bit
    localparam segment_pattern_t digit_patterns [16] = '{
        7'b1111110, 7'b0110000, 7'b1101101, 7'b1111001,
        7'b0110011, 7'b1011011, 7'b1011111, 7'b1110000,
        7'b1111111, 7'b1111011, 7'b1110111, 7'b0011111,
        7'b1001110, 7'b0111101, 7'b1001111, 7'b1000111
    };

    logic                  clk;
    logic                  reset;
    logic                  req_valid;
    logic                  req_write;
    logic [15:0]           req_addr;
    logic [15:0]           req_wdata;
    logic                  req_ready;
    logic                  rsp_valid;
    logic [15:0]           rsp_rdata;
    logic                  rsp_error;
    logic                  rsp_ready;
    segment_pattern_t      segments;
    logic [num_digits-1:0] selection;
    logic                  dot;
    logic                  colon;

    // shadow copy of the three registers
    ctrl_t       model_ctrl     = '0;
    digit_pair_t model_digits01 = '0;
    digit_pair_t model_digits23 = '0;

    logic        check_armed    = 1'b0;
    logic [15:0] expected_rdata = '0;
    logic        expected_error = 1'b0;

    integer seed           = 32'h1e1a49f3;
    int     hold_left      = 0;
    int     fail_count     = 0;
    int     tests_passed   = 0;
    int     tests_failed   = 0;
    int     accepted_count = 0;
    int     response_count = 0;
    int     scan_steps     = 0;
    logic [num_digits-1:0] last_selection = '0;

    clock_gen #(.period(clk_period)) clocks (.clk(clk), .reset(reset));

    seven_segment_peripheral #(
        .refresh_div(refresh_div)
    ) dut (
        .clk      (clk),
        .reset    (reset),
        .req_valid(req_valid),
        .req_write(req_write),
        .req_addr (req_addr),
        .req_wdata(req_wdata),
        .req_ready(req_ready),
        .rsp_valid(rsp_valid),
        .rsp_rdata(rsp_rdata),
        .rsp_error(rsp_error),
        .rsp_ready(rsp_ready),
        .segments (segments),
        .selection(selection),
        .dot      (dot),
        .colon    (colon)
    );

    task automatic log_failure(input string msg);
        $display("[FAIL] %0t %s", $time, msg);
        fail_count++;
    endtask

    function automatic logic addr_in_window(input logic [15:0] addr);
        return (addr >= base_addr) && (addr <= base_addr + 16'd2);
    endfunction

    function automatic reg_data_t model_byte(input reg_offset_t offset);
        case (offset)
            ctrl_offset:     return reg_data_t'(model_ctrl);
            digits01_offset: return reg_data_t'(model_digits01);
            default:         return reg_data_t'(model_digits23);
        endcase
    endfunction

    function automatic void record_write(input reg_offset_t offset, input reg_data_t value);
        case (offset)
            ctrl_offset:     model_ctrl     = ctrl_t'(value);
            digits01_offset: model_digits01 = digit_pair_t'(value);
            default:         model_digits23 = digit_pair_t'(value);
        endcase
    endfunction

    // hex value of the digit picked by a one-hot select
    function automatic hex_digit_t model_nibble(input logic [3:0] sel, input digit_pair_t d01,
                                                input digit_pair_t d23);
        case (sel)
            4'b0001: return d01.low;
            4'b0010: return d01.high;
            4'b0100: return d23.low;
            4'b1000: return d23.high;
            default: return 4'h0;
        endcase
    endfunction

    // next cycle, rsp_ready random unless a stall is pending
    task automatic step_cycle();
        logic [31:0] r;
        @(posedge clk);
        #1;
        r = $random(seed);
        if (hold_left > 0) begin
            rsp_ready = 1'b0;
            hold_left--;
        end else begin
            rsp_ready = r[0];
        end
    endtask

    task automatic transfer(input logic write, input logic [15:0] addr,
                            input logic [15:0] wdata, input int stall);
        logic        hit;
        logic        taken;
        int          waited;
        logic [15:0] delta;
        reg_offset_t offset;
        hit    = addr_in_window(addr);
        delta  = addr - base_addr;
        offset = reg_offset_t'(delta[1:0]);
        // a write still returns the byte from before it lands
        expected_rdata = hit ? {8'h00, model_byte(offset)} : 16'h0000;
        expected_error = !hit;
        check_armed    = 1'b1;
        req_valid = 1'b1;
        req_write = write;
        req_addr  = addr;
        req_wdata = wdata;
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < wait_limit) begin
            @(negedge clk);
            taken = req_ready;
            step_cycle();
            waited++;
        end
        req_valid = 1'b0;
        req_write = 1'b0;
        if (!taken) begin
            log_failure($sformatf("request to %h was never accepted", addr));
            check_armed = 1'b0;
            return;
        end
        if (write && hit) begin
            record_write(offset, wdata[7:0]);
        end
        if (stall > 0) begin
            rsp_ready = 1'b0;
            hold_left = stall - 1;
        end
        taken  = 1'b0;
        waited = 0;
        while (!taken && waited < wait_limit) begin
            @(negedge clk);
            taken = rsp_valid && rsp_ready;
            step_cycle();
            waited++;
        end
        check_armed = 1'b0;
        if (!taken) begin
            log_failure($sformatf("no response came back for the request to %h", addr));
        end
    endtask

    task automatic bus_write(input logic [15:0] addr, input logic [15:0] wdata);
        transfer(1'b1, addr, wdata, 0);
    endtask

    task automatic bus_read(input logic [15:0] addr);
        transfer(1'b0, addr, 16'h0000, 0);
    endtask

    task automatic stalled_read(input logic [15:0] addr, input int cycles);
        transfer(1'b0, addr, 16'h0000, cycles);
    endtask

    task automatic wait_scan(input int steps);
        int target;
        int waited;
        target = scan_steps + steps;
        waited = 0;
        while (scan_steps < target && waited < steps * refresh_div * 4) begin
            step_cycle();
            waited++;
        end
        if (scan_steps < target) begin
            log_failure("the display stopped stepping through its digits");
        end
    endtask

    task automatic finish_test(input string name, input int fails_before);
        if (fail_count == fails_before) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, fail_count - fails_before);
        end
    endtask

    // transfers seen by the DUT
    always @(posedge clk) begin
        if (!reset) begin
            accepted_count <= 0;
            response_count <= 0;
        end else begin
            if (req_valid && req_ready) accepted_count <= accepted_count + 1;
            if (rsp_valid && rsp_ready) response_count <= response_count + 1;
        end
    end

    // digit steps, by one-hot position only
    always @(negedge clk) begin
        if (selection != last_selection && selection != '0) begin
            scan_steps <= scan_steps + 1;
        end
        last_selection <= selection;
    end

    assert property (@(posedge clk) $rose(reset) |->
        (selection == '0 && !dot && !colon && req_ready && !rsp_valid))
        else log_failure("display lit or bus busy right after reset");

    assert property (@(posedge clk) disable iff (!reset)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata) && $stable(rsp_error)))
        else log_failure("a response changed or vanished before the master took it");

    assert property (@(posedge clk) disable iff (!reset)
        (rsp_valid && !rsp_ready) |-> !req_ready)
        else log_failure("a new request was offered while a response was still held");

    assert property (@(posedge clk) disable iff (!reset)
        (accepted_count - response_count) == (rsp_valid ? 1 : 0))
        else log_failure("requests and responses no longer pair up one to one");

    assert property (@(posedge clk) disable iff (!reset)
        (rsp_valid && rsp_ready && check_armed) |->
            (rsp_rdata == expected_rdata && rsp_error == expected_error))
        else log_failure($sformatf("response %h error %b, expected %h error %b",
            $sampled(rsp_rdata), $sampled(rsp_error), expected_rdata, expected_error));

    assert property (@(posedge clk) disable iff (!reset)
        model_ctrl.enable |-> $onehot(selection))
        else log_failure($sformatf("selection %b is not one-hot", $sampled(selection)));

    assert property (@(posedge clk) disable iff (!reset)
        (model_ctrl.enable && $past(model_ctrl.enable) && $past(selection) != '0
            && selection != $past(selection))
        |-> selection == {$past(selection[2:0]), $past(selection[3])})
        else log_failure("digit select left the order 0, 1, 2, 3");

    assert property (@(posedge clk) disable iff (!reset)
        model_ctrl.enable |->
            segments == digit_patterns[model_nibble(selection, model_digits01, model_digits23)])
        else log_failure($sformatf("segments %b wrong for selection %b",
            $sampled(segments), $sampled(selection)));

    assert property (@(posedge clk) disable iff (!reset)
        model_ctrl.enable |-> (dot == |(model_ctrl.dots & selection) && colon == model_ctrl.colon))
        else log_failure($sformatf("dot %b colon %b wrong for selection %b",
            $sampled(dot), $sampled(colon), $sampled(selection)));

    assert property (@(posedge clk) disable iff (!reset)
        !model_ctrl.enable |-> (selection == '0 && !dot && !colon))
        else log_failure("display lit while disabled");

    initial begin
        int          fails_before;
        logic [15:0] data;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr  = '0;
        req_wdata = '0;
        rsp_ready = 1'b0;
        wait (reset === 1'b1);
        step_cycle();

        fails_before = fail_count;
        for (int i = 0; i < num_regs; i++) begin
            bus_read(base_addr + 16'(i));
        end
        finish_test("reset state", fails_before);

        fails_before = fail_count;
        for (int i = 0; i < num_regs; i++) begin
            data = $random(seed);
            data[15:8] = data[15:8] | 8'h81;
            bus_write(base_addr + 16'(i), data);
        end
        for (int i = 0; i < num_regs; i++) begin
            bus_read(base_addr + 16'(i));
        end
        finish_test("write and read back", fails_before);

        // the last three alias offsets 0, 1 and 2 in the low address bits
        fails_before = fail_count;
        bus_write(base_addr + 16'd3, 16'hFFFF);
        bus_read(base_addr + 16'd3);
        bus_write(base_addr - 16'd1, 16'h00FF);
        bus_read(base_addr - 16'd1);
        bus_write(base_addr + 16'd4, {8'h00, ~model_byte(ctrl_offset)});
        bus_write(base_addr + 16'd5, {8'h00, ~model_byte(digits01_offset)});
        bus_write(base_addr - 16'd2, {8'h00, ~model_byte(digits23_offset)});
        for (int i = 0; i < num_regs; i++) begin
            bus_read(base_addr + 16'(i));
        end
        finish_test("out of window", fails_before);

        fails_before = fail_count;
        for (int i = 0; i < num_regs; i++) begin
            stalled_read(base_addr + 16'(i), 6);
        end
        finish_test("back-pressure", fails_before);

        // digit i shows v + i, so every digit sees all sixteen values
        fails_before = fail_count;
        for (int v = 0; v < 16; v++) begin
            data = $random(seed);
            bus_write(base_addr + 16'd1, {8'h00, 4'(v + 1), 4'(v)});
            bus_write(base_addr + 16'd2, {8'h00, 4'(v + 3), 4'(v + 2)});
            bus_write(base_addr, {8'h00, data[7:4], 2'b00, data[1], 1'b1});
            wait_scan(num_digits + 1);
        end
        finish_test("scanning while enabled", fails_before);

        fails_before = fail_count;
        bus_write(base_addr, 16'h00F2);
        repeat (2 * num_digits * refresh_div) step_cycle();
        bus_write(base_addr + 16'd1, 16'h0088);
        repeat (2 * num_digits * refresh_div) step_cycle();
        finish_test("disabled display", fails_before);

        repeat (4) step_cycle();
        $display("tests passed %0d, tests failed %0d, check failures %0d",
                 tests_passed, tests_failed, fail_count);
        if (fail_count == 0 && tests_failed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    initial begin
        #(total_budget * 2 * clk_period);
        $display("run timed out after %0d cycles", total_budget * 2);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// File: verification/clock_gen.sv
// testbench clock and power-on reset for the seven-segment peripheral
`timescale 1ns/1ps

module clock_gen #(
    parameter int period       = 8,
    parameter int reset_cycles = 16
) (
    output logic clk,
    output logic reset
);
    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // released shortly after a rising edge, like every other input
    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        reset = 1'b1;
    end

endmodule

// File: hw/seven_segment_peripheral.sv
// seven-segment display peripheral: bus port, control and digit registers, digit scanner
`timescale 1ns/1ps

module seven_segment_peripheral #(
    parameter int                    addr_width  = 16,
    parameter int                    data_width  = 16,
    parameter logic [addr_width-1:0] base_addr   = 16'hFF10,
    parameter int                    refresh_div = 1024
) (
    input  logic                                   clk,
    input  logic                                   reset,
    // system bus
    input  logic                                   req_valid,
    input  logic                                   req_write,
    input  logic [addr_width-1:0]                  req_addr,
    input  logic [data_width-1:0]                  req_wdata,
    output logic                                   req_ready,
    output logic                                   rsp_valid,
    output logic [data_width-1:0]                  rsp_rdata,
    output logic                                   rsp_error,
    input  logic                                   rsp_ready,
    // display pins, active high
    output seg_display_pkg::segment_pattern_t      segments,
    output logic [seg_display_pkg::num_digits-1:0] selection,
    output logic                                   dot,
    output logic                                   colon
);
    import seg_bus_pkg::*;
    import seg_display_pkg::*;

    logic [num_regs-1:0] reg_write;
    reg_data_t           reg_wdata;
    reg_data_t           ctrl_rdata;
    reg_data_t           digits01_rdata;
    reg_data_t           digits23_rdata;
    ctrl_t               ctrl;
    digit_pair_t         digits01;
    digit_pair_t         digits23;

    bus_slave_port #(
        .addr_width(addr_width),
        .data_width(data_width),
        .base_addr (base_addr)
    ) port (
        .clk       (clk),
        .reset     (reset),
        .req_valid (req_valid),
        .req_write (req_write),
        .req_addr  (req_addr),
        .req_wdata (req_wdata),
        .req_ready (req_ready),
        .rsp_valid (rsp_valid),
        .rsp_rdata (rsp_rdata),
        .rsp_error (rsp_error),
        .rsp_ready (rsp_ready),
        .reg_write (reg_write),
        .reg_wdata (reg_wdata),
        .reg_rdata0(ctrl_rdata),
        .reg_rdata1(digits01_rdata),
        .reg_rdata2(digits23_rdata)
    );

    // all registers clear at reset, display starts disabled
    bus_register #(
        .payload_t  (ctrl_t),
        .reset_value(ctrl_t'(0))
    ) ctrl_reg (
        .clk      (clk),
        .reset    (reset),
        .write    (reg_write[ctrl_offset]),
        .wdata    (reg_wdata),
        .value    (ctrl),
        .read_data(ctrl_rdata)
    );

    bus_register #(
        .payload_t  (digit_pair_t),
        .reset_value(digit_pair_t'(0))
    ) digits01_reg (
        .clk      (clk),
        .reset    (reset),
        .write    (reg_write[digits01_offset]),
        .wdata    (reg_wdata),
        .value    (digits01),
        .read_data(digits01_rdata)
    );

    bus_register #(
        .payload_t  (digit_pair_t),
        .reset_value(digit_pair_t'(0))
    ) digits23_reg (
        .clk      (clk),
        .reset    (reset),
        .write    (reg_write[digits23_offset]),
        .wdata    (reg_wdata),
        .value    (digits23),
        .read_data(digits23_rdata)
    );

    display_scanner #(
        .refresh_div(refresh_div)
    ) scanner (
        .clk      (clk),
        .reset    (reset),
        .ctrl     (ctrl),
        .digits01 (digits01),
        .digits23 (digits23),
        .segments (segments),
        .selection(selection),
        .dot      (dot),
        .colon    (colon)
    );

endmodule

// File: hw/display_scanner.sv
// four-digit seven-segment scanner, multiplexes hex digits onto one segment bus
`timescale 1ns/1ps

module display_scanner #(
    parameter int refresh_div = 1024
) (
    input  logic                                  clk,
    input  logic                                  reset,
    input  seg_display_pkg::ctrl_t                ctrl,
    input  seg_display_pkg::digit_pair_t          digits01,
    input  seg_display_pkg::digit_pair_t          digits23,
    output seg_display_pkg::segment_pattern_t     segments,
    output logic [seg_display_pkg::num_digits-1:0] selection,
    output logic                                  dot,
    output logic                                  colon
);
    import seg_display_pkg::*;

    // at least one bit, so refresh_div of 1 still builds
    localparam int presc_width = (refresh_div > 1) ? $clog2(refresh_div) : 1;

    logic [presc_width-1:0] prescaler;
    logic                   step;
    digit_index_t           digit;
    hex_digit_t             nibble;

    assign step = (prescaler == presc_width'(refresh_div - 1));

    // keeps running while the display is off
    always_ff @(posedge clk) begin
        if (!reset) begin
            prescaler <= '0;
            digit     <= '0;
        end else if (step) begin
            prescaler <= '0;
            // wraps from 3 back to 0
            digit     <= digit + 1'b1;
        end else begin
            prescaler <= prescaler + 1'b1;
        end
    end

    // nibble of the digit currently driven
    always_comb begin
        case (digit)
            2'd0:    nibble = digits01.low;
            2'd1:    nibble = digits01.high;
            2'd2:    nibble = digits23.low;
            2'd3:    nibble = digits23.high;
            default: nibble = '0;
        endcase
    end

    // segments follow the digit even when disabled,
    // nothing lights without a digit select
    assign segments = hex_to_segments(nibble);

    assign selection = ctrl.enable ? (num_digits'(1) << digit) : '0;
    assign dot       = ctrl.enable && ctrl.dots[digit];
    assign colon     = ctrl.enable && ctrl.colon;

endmodule

// File: hw/bus_slave_port.sv
// bus slave port: valid/ready request handshake, window decode, write strobes and held response
`timescale 1ns/1ps

module bus_slave_port #(
    parameter int                    addr_width = 16,
    parameter int                    data_width = 16,
    parameter logic [addr_width-1:0] base_addr  = 16'hFF10
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                req_valid,
    input  logic                                req_write,
    input  logic [addr_width-1:0]               req_addr,
    input  logic [data_width-1:0]               req_wdata,
    output logic                                req_ready,
    output logic                                rsp_valid,
    output logic [data_width-1:0]               rsp_rdata,
    output logic                                rsp_error,
    input  logic                                rsp_ready,
    output logic [seg_bus_pkg::num_regs-1:0]    reg_write,
    output seg_bus_pkg::reg_data_t              reg_wdata,
    input  seg_bus_pkg::reg_data_t              reg_rdata0,
    input  seg_bus_pkg::reg_data_t              reg_rdata1,
    input  seg_bus_pkg::reg_data_t              reg_rdata2
);
    import seg_bus_pkg::*;

    logic                  req_fire;
    logic                  rsp_fire;
    logic [addr_width-1:0] addr_delta;
    logic                  in_window;
    reg_offset_t           offset;
    reg_data_t             read_byte;

    assign req_fire = req_valid && req_ready;
    assign rsp_fire = rsp_valid && rsp_ready;

    // free when nothing is held, or the held response leaves on this edge
    assign req_ready = !rsp_valid || rsp_ready;

    // below base_addr the difference wraps and fails the compare as well
    assign addr_delta = req_addr - base_addr;
    assign in_window  = addr_delta < addr_width'(num_regs);
    assign offset     = reg_offset_t'(addr_delta[offset_width-1:0]);

    // upper bus bits are not stored
    assign reg_wdata = req_wdata[reg_width-1:0];

    // one strobe per register, only for the cycle of an accepted write
    always_comb begin
        reg_write = '0;
        if (req_fire && req_write && in_window) begin
            reg_write[offset] = 1'b1;
        end
    end

    always_comb begin
        case (offset)
            ctrl_offset:     read_byte = reg_rdata0;
            digits01_offset: read_byte = reg_rdata1;
            digits23_offset: read_byte = reg_rdata2;
            default:         read_byte = '0;
        endcase
    end

    // held response, cleared once the master takes it
    always_ff @(posedge clk) begin
        if (!reset) begin
            rsp_valid <= 1'b0;
        end else if (req_fire) begin
            rsp_valid <= 1'b1;
        end else if (rsp_fire) begin
            rsp_valid <= 1'b0;
        end
    end

    // response payload, register value as it was at the accepting edge
    always_ff @(posedge clk) begin
        if (req_fire) begin
            rsp_error <= !in_window;
            if (in_window) begin
                rsp_rdata <= data_width'(read_byte);
            end else begin
                rsp_rdata <= '0;
            end
        end
    end

endmodule

// File: hw/bus_register.sv
// byte-wide read/write register holding one payload type, loaded by a bus write strobe
`timescale 1ns/1ps

module bus_register #(
    parameter type      payload_t   = seg_bus_pkg::reg_data_t,
    parameter payload_t reset_value = payload_t'(0)
) (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   write,
    input  seg_bus_pkg::reg_data_t wdata,
    output payload_t               value,
    output seg_bus_pkg::reg_data_t read_data
);
    import seg_bus_pkg::*;

    // payload is expected to be exactly one register byte wide

    always_ff @(posedge clk) begin
        if (!reset) begin
            value <= reset_value;
        end else if (write) begin
            value <= payload_t'(wdata);
        end
    end

    // same bits, seen as a plain byte for the read path
    assign read_data = reg_data_t'(value);

endmodule

// File: hw/seg_display_pkg.sv
// seven-segment display side: control word, digit pairs and hex-to-segment decode
package seg_display_pkg;

    // digits on the shared segment bus
    localparam int num_digits = 4;

    typedef logic [$clog2(num_digits)-1:0] digit_index_t;

    typedef logic [3:0] hex_digit_t;

    // segments a..g, a in the top bit, 1 = lit
    typedef logic [6:0] segment_pattern_t;

    // control register layout
    typedef struct packed {
        logic [num_digits-1:0] dots;
        logic [1:0]            reserved;
        logic                  colon;
        logic                  enable;
    } ctrl_t;

    // two hex digits per register, even digit in the low nibble
    typedef struct packed {
        hex_digit_t high;
        hex_digit_t low;
    } digit_pair_t;

    //  --a--
    //  f   b
    //  --g--
    //  e   c
    //  --d--
    function automatic segment_pattern_t hex_to_segments(input hex_digit_t value);
        case (value)
            4'h0:    return 7'b1111110;
            4'h1:    return 7'b0110000;
            4'h2:    return 7'b1101101;
            4'h3:    return 7'b1111001;
            4'h4:    return 7'b0110011;
            4'h5:    return 7'b1011011;
            4'h6:    return 7'b1011111;
            4'h7:    return 7'b1110000;
            4'h8:    return 7'b1111111;
            4'h9:    return 7'b1111011;
            4'hA:    return 7'b1110111;
            // lower case b and d, so they differ from 8 and 0
            4'hB:    return 7'b0011111;
            4'hC:    return 7'b1001110;
            4'hD:    return 7'b0111101;
            4'hE:    return 7'b1001111;
            4'hF:    return 7'b1000111;
            default: return '0;
        endcase
    endfunction

endpackage

// File: hw/seg_bus_pkg.sv
// seven-segment peripheral bus side: register map, window size and register byte type
package seg_bus_pkg;

    // one byte per register, whatever the bus data width
    localparam int reg_width = 8;

    typedef logic [reg_width-1:0] reg_data_t;

    // number of byte registers in the address window
    localparam int num_regs = 3;

    // register map, relative to base_addr
    //   0  control: dots[7:4], reserved[3:2], colon[1], enable[0]
    //   1  digits 1 (high nibble) and 0 (low nibble)
    //   2  digits 3 (high nibble) and 2 (low nibble)
    typedef enum logic [1:0] {
        ctrl_offset     = 2'd0,
        digits01_offset = 2'd1,
        digits23_offset = 2'd2
    } reg_offset_t;

    // bits of the address that select a register inside the window
    localparam int offset_width = $bits(reg_offset_t);

endpackage
